// File: src/uart_pkg.sv
// shared definitions for the uart peripheral.
// bit timing, fifo depth, register map and payload types.

package uart_pkg;

   // serial timing.
   localparam int CLKS_PER_BIT = 8;
   localparam int HALF_BIT     = CLKS_PER_BIT / 2;   // start-bit edge to first check.
   localparam int CNT_W        = $clog2(CLKS_PER_BIT);
   localparam int FRAME_BITS   = 10;                  // start, 8 data, stop.

   // entries per fifo.
   localparam int FIFO_DEPTH = 4;

   // wishbone word addresses.
   localparam logic [0:0] ADR_DATA   = 1'b0;
   localparam logic [0:0] ADR_STATUS = 1'b1;

   // status register bit positions.
   localparam int STAT_RX_VALID = 0;
   localparam int STAT_TX_FULL  = 1;
   localparam int STAT_RX_FERR  = 2;
   localparam int STAT_OVERRUN  = 3;

   typedef logic [7:0] byte_t;

   // received byte with its framing status.
   typedef struct packed {
      logic  ferr;
      byte_t data;
   } rx_word_t;

endpackage

// File: src/uart_fifo.sv
// synchronous fifo, first-word fall-through.
// payload type and depth are parameters.

`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; #(
   parameter type T_PAYLOAD = byte_t,
   parameter int  DEPTH     = FIFO_DEPTH
) (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_push,
   input  T_PAYLOAD i_data,
   input  logic     i_pop,
   output T_PAYLOAD o_data,
   output logic     o_empty,
   output logic     o_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T_PAYLOAD         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(DEPTH));
   assign o_data  = mem[rd_ptr];   // head is always visible.

   assign do_pop  = i_pop & ~o_empty;
   assign do_push = i_push & (~o_full | do_pop);   // full fifo still takes a push with a pop.

   always_ff @(posedge i_clk) begin
      if (do_push) mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop) count <= count + 1'b1;
         else if (do_pop && !do_push) count <= count - 1'b1;
      end
   end

endmodule

// File: src/uart_rx.sv
// 8n1 serial receiver at a fixed bit rate.
// two-flop input sync, start-bit check, mid-bit sampling, stop-bit check.

`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_rx,
   output logic     o_push,
   output rx_word_t o_word
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_START,
      S_DATA,
      S_STOP
   } state_t;

   state_t           state;
   logic [CNT_W-1:0] cnt;
   logic [1:0]       sync;
   logic             rx_s;
   byte_t            shreg;
   logic             half_done;
   logic             bit_done;

   assign rx_s      = sync[1];
   assign half_done = (cnt == CNT_W'(HALF_BIT - 1));
   assign bit_done  = (cnt == CNT_W'(CLKS_PER_BIT - 1));

   // word is pushed in the cycle the stop bit is sampled.
   assign o_push      = (state == S_STOP) && bit_done;
   assign o_word.data = shreg;
   assign o_word.ferr = ~rx_s;   // low stop bit.

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) sync <= 2'b11;   // line idles high.
      else sync <= {sync[0], i_rx};
   end

   // marker bit in the msb walks down, done when it reaches bit 0.
   always_ff @(posedge i_clk) begin
      if (state == S_IDLE) shreg <= 8'h80;
      else if (state == S_DATA && bit_done) shreg <= {rx_s, shreg[7:1]};
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= S_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            S_IDLE: if (!rx_s) begin
               state <= S_START;
               cnt   <= '0;
            end
            S_START: if (half_done) begin
               cnt   <= '0;
               state <= rx_s ? S_IDLE : S_DATA;   // high again means a glitch.
            end else cnt <= cnt + 1'b1;
            S_DATA: if (bit_done) begin
               cnt <= '0;
               if (shreg[0]) state <= S_STOP;   // last data bit taken.
            end else cnt <= cnt + 1'b1;
            S_STOP: if (bit_done) state <= S_IDLE;
            else cnt <= cnt + 1'b1;
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// File: src/uart_tx.sv
// 8n1 serial transmitter.
// pulls bytes from the transmit fifo, frames back to back.

`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_empty,
   input  byte_t i_data,
   output logic  o_pop,
   output logic  o_tx
);

   logic                  busy;
   logic [FRAME_BITS-1:0] shreg;
   logic [CNT_W-1:0]      cnt;
   logic [3:0]            bit_cnt;
   logic                  bit_done;
   logic                  last_bit;

   assign bit_done = (cnt == CNT_W'(CLKS_PER_BIT - 1));
   assign last_bit = bit_done && (bit_cnt == 4'(FRAME_BITS - 1));

   // take the next byte when idle or at the end of the stop bit.
   assign o_pop = (~busy | last_bit) & ~i_empty;
   assign o_tx  = shreg[0];

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy    <= 1'b0;
         shreg   <= '1;   // line high when idle.
         cnt     <= '0;
         bit_cnt <= '0;
      end else if (o_pop) begin
         busy    <= 1'b1;
         shreg   <= {1'b1, i_data, 1'b0};   // stop, data, start.
         cnt     <= '0;
         bit_cnt <= '0;
      end else if (busy) begin
         if (bit_done) begin
            cnt     <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            shreg   <= {1'b1, shreg[FRAME_BITS-1:1]};   // ones fill behind.
            if (last_bit) busy <= 1'b0;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

// File: src/uart_wb_regs.sv
// wishbone classic slave for the uart.
// data and status registers, fifo push and pop, sticky overrun flag.
// ack one cycle after a new access, side effects on the same edge.

`timescale 1ns/1ps

module uart_wb_regs import uart_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_wb_cyc,
   input  logic       i_wb_stb,
   input  logic       i_wb_we,
   input  logic [0:0] i_wb_adr,
   input  byte_t      i_wb_dat,
   output byte_t      o_wb_dat,
   output logic       o_wb_ack,
   output logic       o_tx_push,
   output byte_t      o_tx_data,
   input  logic       i_tx_full,
   output logic       o_rx_pop,
   input  rx_word_t   i_rx_word,
   input  logic       i_rx_empty,
   input  logic       i_rx_push,
   input  logic       i_rx_full
);

   logic  new_acc;
   logic  sel_data;
   logic  sel_status;
   logic  ovr_clr;
   logic  overrun;
   byte_t status;
   byte_t rd_data;

   // decode.
   assign new_acc    = i_wb_cyc & i_wb_stb & ~o_wb_ack;   // held until ack, so once.
   assign sel_data   = (i_wb_adr == ADR_DATA);
   assign sel_status = (i_wb_adr == ADR_STATUS);

   // execute.
   assign o_tx_push = new_acc & i_wb_we & sel_data;   // fifo drops it when full.
   assign o_tx_data = i_wb_dat;
   assign o_rx_pop  = new_acc & ~i_wb_we & sel_data & ~i_rx_empty;
   assign ovr_clr   = new_acc & i_wb_we & sel_status;

   always_comb begin
      status                = '0;
      status[STAT_RX_VALID] = ~i_rx_empty;
      status[STAT_TX_FULL]  = i_tx_full;
      status[STAT_RX_FERR]  = ~i_rx_empty & i_rx_word.ferr;   // head word only.
      status[STAT_OVERRUN]  = overrun;
   end

   // empty fifo reads as zero.
   assign rd_data = sel_status ? status : (i_rx_empty ? '0 : i_rx_word.data);

   // a push on a full fifo is lost unless a pop frees a slot on the same edge.
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) overrun <= 1'b0;
      else if (i_rx_push && i_rx_full && !o_rx_pop) overrun <= 1'b1;
      else if (ovr_clr) overrun <= 1'b0;
   end

   // result.
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_wb_ack <= 1'b0;
         o_wb_dat <= '0;
      end else begin
         o_wb_ack <= new_acc;
         if (new_acc && !i_wb_we) o_wb_dat <= rd_data;
      end
   end

endmodule

// File: src/uart_top.sv
// uart peripheral top level.
// bus block, receive and transmit fifos, receiver and transmitter.

`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_wb_cyc,
   input  logic       i_wb_stb,
   input  logic       i_wb_we,
   input  logic [0:0] i_wb_adr,
   input  byte_t      i_wb_dat,
   output byte_t      o_wb_dat,
   output logic       o_wb_ack,
   input  logic       i_rx,
   output logic       o_tx
);

   // receive side.
   logic     rx_push;
   logic     rx_pop;
   logic     rx_empty;
   logic     rx_full;
   rx_word_t rx_in_word;
   rx_word_t rx_head;

   // transmit side.
   logic  tx_push;
   logic  tx_pop;
   logic  tx_empty;
   logic  tx_full;
   byte_t tx_in_data;
   byte_t tx_head;

   uart_wb_regs regs (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .i_wb_we    (i_wb_we),
      .i_wb_adr   (i_wb_adr),
      .i_wb_dat   (i_wb_dat),
      .o_wb_dat   (o_wb_dat),
      .o_wb_ack   (o_wb_ack),
      .o_tx_push  (tx_push),
      .o_tx_data  (tx_in_data),
      .i_tx_full  (tx_full),
      .o_rx_pop   (rx_pop),
      .i_rx_word  (rx_head),
      .i_rx_empty (rx_empty),
      .i_rx_push  (rx_push),
      .i_rx_full  (rx_full)
   );

   uart_fifo #(.T_PAYLOAD(rx_word_t), .DEPTH(FIFO_DEPTH)) rx_fifo (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_push  (rx_push),
      .i_data  (rx_in_word),
      .i_pop   (rx_pop),
      .o_data  (rx_head),
      .o_empty (rx_empty),
      .o_full  (rx_full)
   );

   uart_fifo #(.T_PAYLOAD(byte_t), .DEPTH(FIFO_DEPTH)) tx_fifo (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_push  (tx_push),
      .i_data  (tx_in_data),
      .i_pop   (tx_pop),
      .o_data  (tx_head),
      .o_empty (tx_empty),
      .o_full  (tx_full)
   );

   uart_rx rx (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_rx   (i_rx),
      .o_push (rx_push),
      .o_word (rx_in_word)
   );

   uart_tx tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_empty (tx_empty),
      .i_data  (tx_head),
      .o_pop   (tx_pop),
      .o_tx    (o_tx)
   );

endmodule

// File: tb/tb_clkgen.sv
// testbench clock and reset generator.
// 40 ns clock, active-low reset held for 10 cycles.

`timescale 1ns/1ps

module tb_clkgen (
   output logic o_clk,
   output logic o_nrst
);

   localparam real HALF_PERIOD = 20.0;
   localparam int  RST_CYCLES  = 10;

   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD) o_clk = ~o_clk;
   end

   initial begin
      o_nrst = 1'b0;
      repeat (RST_CYCLES) @(posedge o_clk);
      @(negedge o_clk);   // release away from the active edge.
      o_nrst = 1'b1;
   end

endmodule

// File: tb/tb_uart.sv
// testbench for the uart peripheral.
// lfsr stimulus, serial line driver and monitor, wishbone tasks, reference model.

`timescale 1ns/1ps

module tb_uart import uart_pkg::*; ();

   localparam int ACK_WAIT       = 4;
   localparam int TIMEOUT_CYCLES = 40 * FRAME_BITS * CLKS_PER_BIT + 2000;

   logic       clk;
   logic       nrst;
   logic       i_wb_cyc;
   logic       i_wb_stb;
   logic       i_wb_we;
   logic [0:0] i_wb_adr;
   byte_t      i_wb_dat;
   byte_t      o_wb_dat;
   logic       o_wb_ack;
   logic       i_rx;
   logic       o_tx;

   logic [31:0] lfsr = 32'h3163cdf5;
   byte_t       exp_tx[$];   // bytes still to appear on o_tx.
   rx_word_t    exp_rx[$];   // model of the receive fifo.
   logic        model_ovr = 1'b0;
   int          cycles = 0;

   tb_clkgen clkgen (.o_clk(clk), .o_nrst(nrst));

   uart_top uut (
      .i_clk(clk), .i_nrst(nrst), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
      .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
      .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack), .i_rx(i_rx), .o_tx(o_tx)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
   endfunction

   function automatic byte_t random_byte();
      byte_t b;
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_next(lfsr);
         b[i] = lfsr[0];   // one step per bit.
      end
      return b;
   endfunction

   task automatic stop_with_failure();
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input byte_t got, input byte_t exp, input string what);
      assert (got === exp) else begin
         $display("mismatch at %0t: %s is %02h, expected %02h", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   // one wishbone access, entered and left on a falling edge.
   task automatic bus_access(input logic we, input logic [0:0] adr, input byte_t wdat,
                             output byte_t rdat);
      int waited;
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      i_wb_we  = we;
      i_wb_adr = adr;
      i_wb_dat = wdat;
      waited   = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (o_wb_ack !== 1'b1 && waited < ACK_WAIT);
      assert (o_wb_ack === 1'b1) else begin
         $display("no wishbone ack within %0d cycles at %0t", ACK_WAIT, $time);
         stop_with_failure();
      end
      rdat     = o_wb_dat;
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
   endtask

   // expected status from the model, tx full given by the caller.
   function automatic byte_t model_status(input logic tx_full);
      byte_t s;
      s = '0;
      s[STAT_RX_VALID] = (exp_rx.size() != 0);
      s[STAT_TX_FULL]  = tx_full;
      s[STAT_RX_FERR]  = (exp_rx.size() != 0) && exp_rx[0].ferr;
      s[STAT_OVERRUN]  = model_ovr;
      return s;
   endfunction

   task automatic check_status(input logic tx_full);
      byte_t got;
      bus_access(1'b0, ADR_STATUS, 8'h00, got);
      check_value(got, model_status(tx_full), "status register");
   endtask

   task automatic check_data_read();
      byte_t    got;
      rx_word_t w;
      bus_access(1'b0, ADR_DATA, 8'h00, got);
      w = '0;   // empty fifo reads as zero.
      if (exp_rx.size() != 0) w = exp_rx.pop_front();
      check_value(got, w.data, "receive data");
   endtask

   // 8n1 frame on i_rx, then the model takes the word or flags overrun.
   task automatic send_frame(input byte_t b, input logic stop);
      logic [9:0] frame;
      rx_word_t   w;
      frame = {stop, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         i_rx = frame[i];
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
      i_rx = 1'b1;
      if (!stop) repeat (CLKS_PER_BIT) @(negedge clk);   // false start after a low stop bit.
      w.data = b;
      w.ferr = ~stop;
      if (exp_rx.size() < FIFO_DEPTH) exp_rx.push_back(w);
      else model_ovr = 1'b1;
   endtask

   // samples o_tx in the middle of every bit.
   initial begin : tx_monitor
      byte_t exp;
      @(posedge nrst);
      forever begin
         @(negedge clk);
         if (o_tx === 1'b0) begin
            assert (exp_tx.size() != 0) else begin
               $display("frame on o_tx at %0t with no byte written for it", $time);
               stop_with_failure();
            end
            exp = exp_tx[0];
            repeat (HALF_BIT - 1) @(negedge clk);
            check_value({7'b0, o_tx}, 8'h00, "o_tx start bit");
            for (int i = 0; i < 8; i++) begin
               repeat (CLKS_PER_BIT) @(negedge clk);
               check_value({7'b0, o_tx}, {7'b0, exp[i]}, "o_tx data bit");
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_value({7'b0, o_tx}, 8'h01, "o_tx stop bit");
            void'(exp_tx.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_with_failure();
      end
   end

   initial begin : main
      byte_t b;
      byte_t st;
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
      i_wb_adr = 1'b0;
      i_wb_dat = 8'h00;
      i_rx     = 1'b1;
      @(posedge nrst);
      @(negedge clk);
      check_value({7'b0, o_tx}, 8'h01, "o_tx after reset");
      check_value({7'b0, o_wb_ack}, 8'h00, "o_wb_ack after reset");
      check_status(1'b0);

      // transmit path, poll for room before each write.
      for (int n = 0; n < 12; n++) begin
         do bus_access(1'b0, ADR_STATUS, 8'h00, st); while (st[STAT_TX_FULL]);
         b = random_byte();
         exp_tx.push_back(b);
         bus_access(1'b1, ADR_DATA, b, st);
      end
      while (exp_tx.size() != 0) @(negedge clk);

      // receive path, each byte read right after it arrives.
      for (int n = 0; n < 12; n++) begin
         send_frame(random_byte(), 1'b1);
         check_status(1'b0);
         check_data_read();
         check_status(1'b0);
         check_data_read();
      end

      // framing error.
      send_frame(random_byte(), 1'b0);
      check_status(1'b0);
      check_data_read();
      check_status(1'b0);

      // overrun, no reads until all frames are in.
      for (int n = 0; n < FIFO_DEPTH + 2; n++) send_frame(random_byte(), 1'b1);
      check_status(1'b0);
      for (int n = 0; n < FIFO_DEPTH; n++) check_data_read();
      check_data_read();
      check_status(1'b0);
      bus_access(1'b1, ADR_STATUS, random_byte(), st);
      model_ovr = 1'b0;
      check_status(1'b0);

      // transmit full, first byte goes straight to the shifter.
      for (int n = 0; n < FIFO_DEPTH + 2; n++) begin
         b = random_byte();
         if (n <= FIFO_DEPTH) exp_tx.push_back(b);
         bus_access(1'b1, ADR_DATA, b, st);
         if (n == FIFO_DEPTH) check_status(1'b1);
      end
      while (exp_tx.size() != 0) @(negedge clk);
      repeat (2 * FRAME_BITS * CLKS_PER_BIT) @(negedge clk);   // room for a stray frame.
      check_value({7'b0, o_tx}, 8'h01, "o_tx idle at the end");

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: verilog.f
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_wb_regs.sv
src/uart_top.sv
tb/tb_clkgen.sv
tb/tb_uart.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LFLAGS    := --lint-only -Wall --timing --timescale 1ns/1ps
TOP       := tb_uart
RTL_TOP   := uart_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
